//--- verilog/mb128_proto_pkg.sv
`default_nettype none

package mb128_proto_pkg;

  // --------------------------------------------------
  // joypad protocol constants
  // --------------------------------------------------
  // train-up pattern the host shifts in lsb first
  localparam logic [7:0] SYNC_BYTE = 8'hA8;
  // bits that must be seen before a sync can match
  localparam int SYNC_MIN_BITS = 8;
  // clk_sys cycles between pad samples, minus one
  localparam logic [1:0] SAMPLE_DIV = 2'd2;

  // request field widths on the wire
  localparam int ADDR_BITS = 10;
  localparam int LEN_BITS_BITS = 3;
  localparam int LEN_BYTES_BITS = 17;

  // trailing host clocks before returning to idle
  localparam int TRAIL_READ = 3;
  localparam int TRAIL_WRITE = 5;

  // --------------------------------------------------
  // protocol engine states
  // --------------------------------------------------
  typedef enum logic [3:0] {
    IDLE, SYNC_ACK, IDENT, REQ, ADDR, LEN_BITS, LEN_BYTES,
    READ, READ_BITS, READ_TRAIL, WRITE, WRITE_BITS, WRITE_TRAIL
  } proto_state_e;

  // one pad sample
  // rise pulses for a single cycle, data and level hold until the next sample
  typedef struct packed {
    logic rise;
    logic data;
    logic level;
  } pad_sample_t;

endpackage

`default_nettype wire

//--- verilog/spi_mem_pkg.sv
`default_nettype none

package spi_mem_pkg;

  // byte address into the serial memory
  // the 10-bit wire address lands in the top bits, so one step is 128 bytes
  localparam int MEM_ADDR_W = 17;
  // address field of the spi frame
  localparam int SPI_ADDR_W = 24;
  // command queue depth, also the number of credits
  localparam int SPI_CMD_DEPTH = 2;

  // --------------------------------------------------
  // serial memory opcodes
  // --------------------------------------------------
  typedef enum logic [7:0] {
    OP_WRITE = 8'h02,
    OP_READ  = 8'h03,
    OP_WREN  = 8'h06
  } spi_op_e;

  // command from the protocol engine
  typedef struct packed {
    spi_op_e               op;
    logic [MEM_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
  } spi_cmd_t;

  // read data back to the protocol engine
  typedef struct packed {
    logic       valid;
    logic [7:0] rdata;
  } spi_rsp_t;

endpackage

`default_nettype wire

//--- verilog/joypad_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module joypad_sampler (
  input  wire                          i_clk_sys,
  input  wire                          i_reset_n,
  input  wire                          i_pad_clk,
  input  wire                          i_pad_data,
  output mb128_proto_pkg::pad_sample_t o_sample
);

  // sample rate divider
  logic [$bits(mb128_proto_pkg::SAMPLE_DIV)-1:0] div_cnt;

  always_ff @(posedge i_clk_sys)
  begin
    if (!i_reset_n)
    begin
      div_cnt  <= mb128_proto_pkg::SAMPLE_DIV;
      o_sample <= '0;
    end
    else
    begin
      // rise only lasts one cycle
      o_sample.rise <= 1'b0;
      if (div_cnt == '0)
      begin
        div_cnt        <= mb128_proto_pkg::SAMPLE_DIV;
        // level still holds the previous sample of the pad clock here
        o_sample.rise  <= i_pad_clk & ~o_sample.level;
        o_sample.level <= i_pad_clk;
        o_sample.data  <= i_pad_data;
      end
      else
        div_cnt <= div_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mb128_protocol.sv
`timescale 1ns/1ps
`default_nettype none

module mb128_protocol (
  input  wire                          i_clk_sys,
  input  wire                          i_reset_n,
  input  wire mb128_proto_pkg::pad_sample_t i_sample,
  output spi_mem_pkg::spi_cmd_t        o_cmd,
  output logic                         o_cmd_valid,
  input  wire                          i_credit,
  input  wire spi_mem_pkg::spi_rsp_t   i_rsp,
  output logic                         o_active,
  output logic                         o_data,
  output logic                         o_ident
);

  mb128_proto_pkg::proto_state_e state;
  logic [7:0] shreg;
  logic [4:0] bit_cnt;
  logic [4:0] trail_last;
  logic is_read;
  logic stop_active;
  logic [mb128_proto_pkg::ADDR_BITS-1:0] wire_addr;
  logic [mb128_proto_pkg::LEN_BITS_BITS-1:0] len_bits;
  logic [mb128_proto_pkg::LEN_BYTES_BITS-1:0] len_bytes, nbytes;
  logic [spi_mem_pkg::MEM_ADDR_W-1:0] cur_addr, base_addr;
  logic [7:0] sync_win, rd_byte, wr_byte, fetch_byte, merged_byte;
  logic [1:0] credits;
  // pending commands issued in order from slot 0
  spi_mem_pkg::spi_cmd_t pend_q [2];
  logic [1:0] pend_n;

  // shift registers as they look after the current bit
  assign sync_win  = {i_sample.data, shreg[7:1]};
  assign nbytes    = {i_sample.data, len_bytes[mb128_proto_pkg::LEN_BYTES_BITS-1:1]};
  assign base_addr = {i_sample.data, wire_addr[mb128_proto_pkg::ADDR_BITS-1:1],
                      {(spi_mem_pkg::MEM_ADDR_W - mb128_proto_pkg::ADDR_BITS){1'b0}}};
  assign trail_last = is_read ? 5'(mb128_proto_pkg::TRAIL_READ - 1) :
                                5'(mb128_proto_pkg::TRAIL_WRITE - 1);

  // fetched byte with the current host bit dropped in
  always_comb
  begin
    merged_byte = fetch_byte;
    merged_byte[bit_cnt[2:0]] = i_sample.data;
  end

  assign o_cmd       = pend_q[0];
  assign o_cmd_valid = (pend_n != 2'd0) && (credits != 2'd0);

  // --------------------------------------------------
  // credit counter
  // --------------------------------------------------
  always_ff @(posedge i_clk_sys)
  begin
    if (!i_reset_n)
      credits <= 2'(spi_mem_pkg::SPI_CMD_DEPTH);
    else if (o_cmd_valid && !i_credit)
      credits <= credits - 2'd1;
    else if (i_credit && !o_cmd_valid)
      credits <= credits + 2'd1;
  end

  // --------------------------------------------------
  // protocol fsm
  // --------------------------------------------------
  always_ff @(posedge i_clk_sys)
  begin
    if (!i_reset_n)
    begin
      state       <= mb128_proto_pkg::IDLE;
      shreg       <= '0;
      bit_cnt     <= '0;
      is_read     <= 1'b0;
      stop_active <= 1'b0;
      wire_addr   <= '0;
      len_bits    <= '0;
      len_bytes   <= '0;
      cur_addr    <= '0;
      pend_n      <= 2'd0;
      o_active    <= 1'b0;
      o_data      <= 1'b0;
      o_ident     <= 1'b0;
    end
    else
    begin
      // head leaves as soon as a credit allows
      if (o_cmd_valid)
      begin
        pend_q[0] <= pend_q[1];
        pend_n    <= pend_n - 2'd1;
      end
      // active drops once the pad clock is seen low after the trail
      if (stop_active && !i_sample.level)
      begin
        o_active    <= 1'b0;
        stop_active <= 1'b0;
      end
      if (i_sample.rise)
      begin
        o_data  <= 1'b0;
        o_ident <= 1'b0;
        case (state)
          mb128_proto_pkg::IDLE:
          begin
            shreg <= sync_win;
            if (bit_cnt < 5'(mb128_proto_pkg::SYNC_MIN_BITS))
              bit_cnt <= bit_cnt + 5'd1;
            if (sync_win == mb128_proto_pkg::SYNC_BYTE &&
                bit_cnt >= 5'(mb128_proto_pkg::SYNC_MIN_BITS - 1))
            begin
              o_active    <= 1'b1;
              stop_active <= 1'b0;
              bit_cnt     <= '0;
              state       <= mb128_proto_pkg::SYNC_ACK;
            end
          end
          mb128_proto_pkg::SYNC_ACK:
            state <= mb128_proto_pkg::IDENT;
          mb128_proto_pkg::IDENT:
          begin
            // the host's own bit is echoed back as ident
            o_ident <= i_sample.data;
            state   <= mb128_proto_pkg::REQ;
          end
          mb128_proto_pkg::REQ:
          begin
            is_read   <= i_sample.data;
            wire_addr <= '0;
            len_bits  <= '0;
            len_bytes <= '0;
            state     <= mb128_proto_pkg::ADDR;
          end
          mb128_proto_pkg::ADDR:
          begin
            wire_addr <= base_addr[spi_mem_pkg::MEM_ADDR_W-1 -: mb128_proto_pkg::ADDR_BITS];
            bit_cnt   <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(mb128_proto_pkg::ADDR_BITS - 1))
            begin
              bit_cnt  <= '0;
              state    <= mb128_proto_pkg::LEN_BITS;
              cur_addr <= base_addr;
              // reads prefetch the first byte right away
              if (is_read)
              begin
                pend_q[0] <= '{spi_mem_pkg::OP_READ, base_addr, 8'h00};
                pend_n    <= 2'd1;
                cur_addr  <= base_addr + 1'b1;
              end
            end
          end
          mb128_proto_pkg::LEN_BITS:
          begin
            len_bits <= {i_sample.data, len_bits[mb128_proto_pkg::LEN_BITS_BITS-1:1]};
            bit_cnt  <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(mb128_proto_pkg::LEN_BITS_BITS - 1))
            begin
              bit_cnt <= '0;
              state   <= mb128_proto_pkg::LEN_BYTES;
            end
          end
          mb128_proto_pkg::LEN_BYTES:
          begin
            len_bytes <= nbytes;
            bit_cnt   <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(mb128_proto_pkg::LEN_BYTES_BITS - 1))
            begin
              bit_cnt <= '0;
              o_data  <= is_read;
              // a partial write fetches the final byte so its upper bits survive
              if (!is_read && len_bits != '0)
              begin
                pend_q[0] <= '{spi_mem_pkg::OP_READ, cur_addr + nbytes, 8'h00};
                pend_n    <= 2'd1;
              end
              if (nbytes != '0)
                state <= is_read ? mb128_proto_pkg::READ : mb128_proto_pkg::WRITE;
              else if (len_bits != '0)
                state <= is_read ? mb128_proto_pkg::READ_BITS : mb128_proto_pkg::WRITE_BITS;
              else
                state <= is_read ? mb128_proto_pkg::READ_TRAIL : mb128_proto_pkg::WRITE_TRAIL;
            end
          end
          mb128_proto_pkg::READ:
          begin
            o_data  <= rd_byte[0];
            rd_byte <= {1'b0, rd_byte[7:1]};
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'd7)
            begin
              bit_cnt <= '0;
              if (len_bytes == 1 && len_bits == '0)
                state <= mb128_proto_pkg::READ_TRAIL;
              else
              begin
                // prefetch the next byte at the boundary
                pend_q[0] <= '{spi_mem_pkg::OP_READ, cur_addr, 8'h00};
                pend_n    <= 2'd1;
                cur_addr  <= cur_addr + 1'b1;
                if (len_bytes == 1)
                  state <= mb128_proto_pkg::READ_BITS;
                else
                  len_bytes <= len_bytes - 1'b1;
              end
            end
          end
          mb128_proto_pkg::READ_BITS:
          begin
            o_data  <= rd_byte[0];
            rd_byte <= {1'b0, rd_byte[7:1]};
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt[2:0] + 3'd1 == len_bits)
            begin
              bit_cnt <= '0;
              state   <= mb128_proto_pkg::READ_TRAIL;
            end
          end
          mb128_proto_pkg::WRITE:
          begin
            wr_byte[bit_cnt[2:0]] <= i_sample.data;
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'd7)
            begin
              bit_cnt <= '0;
              // the memory drops its write latch after each write
              pend_q[0] <= '{spi_mem_pkg::OP_WREN, '0, 8'h00};
              pend_q[1] <= '{spi_mem_pkg::OP_WRITE, cur_addr, {i_sample.data, wr_byte[6:0]}};
              pend_n    <= 2'd2;
              cur_addr  <= cur_addr + 1'b1;
              if (len_bytes != 1)
                len_bytes <= len_bytes - 1'b1;
              else if (len_bits != '0)
                state <= mb128_proto_pkg::WRITE_BITS;
              else
                state <= mb128_proto_pkg::WRITE_TRAIL;
            end
          end
          mb128_proto_pkg::WRITE_BITS:
          begin
            fetch_byte <= merged_byte;
            bit_cnt    <= bit_cnt + 5'd1;
            if (bit_cnt[2:0] + 3'd1 == len_bits)
            begin
              pend_q[0] <= '{spi_mem_pkg::OP_WREN, '0, 8'h00};
              pend_q[1] <= '{spi_mem_pkg::OP_WRITE, cur_addr, merged_byte};
              pend_n    <= 2'd2;
              bit_cnt   <= '0;
              state     <= mb128_proto_pkg::WRITE_TRAIL;
            end
          end
          mb128_proto_pkg::READ_TRAIL, mb128_proto_pkg::WRITE_TRAIL:
          begin
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == trail_last)
            begin
              bit_cnt     <= '0;
              shreg       <= '0;
              stop_active <= 1'b1;
              state       <= mb128_proto_pkg::IDLE;
            end
          end
          default:
          begin
            bit_cnt     <= '0;
            stop_active <= 1'b1;
            state       <= mb128_proto_pkg::IDLE;
          end
        endcase
      end
      // read data lands after any shift of the same cycle
      if (i_rsp.valid)
      begin
        if (is_read)
          rd_byte <= i_rsp.rdata;
        else
          fetch_byte <= i_rsp.rdata;
      end
    end
  end

  // credits come back only for commands that were issued
  a_credit_max: assert property (@(posedge i_clk_sys) disable iff (!i_reset_n)
    credits <= 2'(spi_mem_pkg::SPI_CMD_DEPTH));
  // commands queued at one pad rise have all left before the next one
  a_queue_drained: assert property (@(posedge i_clk_sys) disable iff (!i_reset_n)
    i_sample.rise |-> pend_n == 2'd0);

endmodule

`default_nettype wire

//--- verilog/spi_mem_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mem_master (
  input  wire                        i_clk_sys,
  input  wire                        i_reset_n,
  input  wire spi_mem_pkg::spi_cmd_t i_cmd,
  input  wire                        i_cmd_valid,
  output logic                       o_credit,
  output spi_mem_pkg::spi_rsp_t      o_rsp,
  output logic                       o_sp_cs_n,
  output logic                       o_sp_clk,
  output logic                       o_sp_mosi,
  output logic                       o_sp_hold_n,
  input  wire                        i_sp_miso
);

  typedef enum logic {ENG_IDLE, ENG_BUSY} eng_state_e;

  // command queue
  spi_mem_pkg::spi_cmd_t fifo_q [spi_mem_pkg::SPI_CMD_DEPTH];
  spi_mem_pkg::spi_cmd_t head;
  logic wr_ptr, rd_ptr, pop;
  logic [1:0] fifo_cnt;

  // bit engine
  eng_state_e eng_state;
  spi_mem_pkg::spi_op_e cur_op;
  logic [1:0] phase;
  // opcode, address and data byte, msb first
  logic [spi_mem_pkg::SPI_ADDR_W+15:0] frame;
  logic [5:0] bits_left;
  logic [7:0] rx_byte;

  assign head = fifo_q[rd_ptr];
  // a new command only starts at a phase boundary
  assign pop = (eng_state == ENG_IDLE) && (phase == 2'd3) && (fifo_cnt != 2'd0);

  // --------------------------------------------------
  // two-entry fifo
  // --------------------------------------------------
  always_ff @(posedge i_clk_sys)
  begin
    if (i_cmd_valid)
      fifo_q[wr_ptr] <= i_cmd;
  end

  always_ff @(posedge i_clk_sys)
  begin
    if (!i_reset_n)
    begin
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      fifo_cnt <= 2'd0;
    end
    else
    begin
      if (i_cmd_valid)
        wr_ptr <= ~wr_ptr;
      if (pop)
        rd_ptr <= ~rd_ptr;
      if (i_cmd_valid && !pop)
        fifo_cnt <= fifo_cnt + 2'd1;
      else if (pop && !i_cmd_valid)
        fifo_cnt <= fifo_cnt - 2'd1;
    end
  end

  // --------------------------------------------------
  // four-phase bit engine
  // --------------------------------------------------
  always_ff @(posedge i_clk_sys)
  begin
    if (!i_reset_n)
    begin
      eng_state   <= ENG_IDLE;
      phase       <= 2'd0;
      bits_left   <= 6'd0;
      o_credit    <= 1'b0;
      o_rsp       <= '0;
      o_sp_cs_n   <= 1'b1;
      o_sp_clk    <= 1'b0;
      o_sp_mosi   <= 1'b0;
      o_sp_hold_n <= 1'b0;
    end
    else
    begin
      phase       <= phase + 2'd1;
      o_credit    <= 1'b0;
      o_rsp.valid <= 1'b0;
      case (eng_state)
        ENG_IDLE:
          if (pop)
          begin
            cur_op    <= head.op;
            eng_state <= ENG_BUSY;
            // wren is opcode only
            if (head.op == spi_mem_pkg::OP_WREN)
            begin
              frame     <= {head.op, {(spi_mem_pkg::SPI_ADDR_W + 8){1'b0}}};
              bits_left <= 6'd8;
            end
            else
            begin
              frame <= {head.op,
                        {(spi_mem_pkg::SPI_ADDR_W - spi_mem_pkg::MEM_ADDR_W){1'b0}},
                        head.addr, head.wdata};
              bits_left <= 6'd40;
            end
          end
        default:
          case (phase)
            2'd0:
            begin
              // select held low for the whole command
              o_sp_cs_n   <= 1'b0;
              o_sp_hold_n <= 1'b1;
              o_sp_mosi   <= frame[spi_mem_pkg::SPI_ADDR_W+15];
              frame       <= {frame[spi_mem_pkg::SPI_ADDR_W+14:0], 1'b0};
            end
            2'd1:
              o_sp_clk <= 1'b1;
            2'd2:
            begin
              // only the last 8 bits matter for a read
              rx_byte   <= {rx_byte[6:0], i_sp_miso};
              bits_left <= bits_left - 6'd1;
            end
            default:
            begin
              o_sp_clk <= 1'b0;
              if (bits_left == 6'd0)
              begin
                o_sp_cs_n   <= 1'b1;
                o_sp_hold_n <= 1'b0;
                o_sp_mosi   <= 1'b0;
                o_credit    <= 1'b1;
                o_rsp.valid <= (cur_op == spi_mem_pkg::OP_READ);
                o_rsp.rdata <= rx_byte;
                eng_state   <= ENG_IDLE;
              end
            end
          endcase
      endcase
    end
  end

  // the sender's credit count must keep the queue from overflowing
  a_no_overflow: assert property (@(posedge i_clk_sys) disable iff (!i_reset_n)
    i_cmd_valid |-> fifo_cnt != 2'(spi_mem_pkg::SPI_CMD_DEPTH));

endmodule

`default_nettype wire

//--- verilog/mb128_top.sv
`timescale 1ns/1ps
`default_nettype none

module mb128_top (
  input  wire  i_clk_sys,
  input  wire  i_reset_n,
  // joypad side
  input  wire  i_pad_clk,
  input  wire  i_pad_data,
  output logic o_active,
  output logic o_data,
  output logic o_ident,
  // serial memory side
  output logic o_sp_cs_n,
  output logic o_sp_clk,
  output logic o_sp_mosi,
  output logic o_sp_hold_n,
  input  wire  i_sp_miso
);

  mb128_proto_pkg::pad_sample_t sample;
  spi_mem_pkg::spi_cmd_t cmd;
  spi_mem_pkg::spi_rsp_t rsp;
  logic cmd_valid;
  logic credit;

  joypad_sampler u_sampler (
    .i_clk_sys (i_clk_sys),
    .i_reset_n (i_reset_n),
    .i_pad_clk (i_pad_clk),
    .i_pad_data(i_pad_data),
    .o_sample  (sample)
  );

  mb128_protocol u_protocol (
    .i_clk_sys  (i_clk_sys),
    .i_reset_n  (i_reset_n),
    .i_sample   (sample),
    .o_cmd      (cmd),
    .o_cmd_valid(cmd_valid),
    .i_credit   (credit),
    .i_rsp      (rsp),
    .o_active   (o_active),
    .o_data     (o_data),
    .o_ident    (o_ident)
  );

  spi_mem_master u_spi (
    .i_clk_sys  (i_clk_sys),
    .i_reset_n  (i_reset_n),
    .i_cmd      (cmd),
    .i_cmd_valid(cmd_valid),
    .o_credit   (credit),
    .o_rsp      (rsp),
    .o_sp_cs_n  (o_sp_cs_n),
    .o_sp_clk   (o_sp_clk),
    .o_sp_mosi  (o_sp_mosi),
    .o_sp_hold_n(o_sp_hold_n),
    .i_sp_miso  (i_sp_miso)
  );

endmodule

`default_nettype wire

//--- test/spi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_mem_model (
  input  wire         i_clk_sys,
  input  wire         i_reset_n,
  input  wire         i_cs_n,
  input  wire         i_sclk,
  input  wire         i_mosi,
  input  wire         i_hold_n,
  output logic        o_miso,
  output logic [15:0] o_wren_cnt,
  output logic [15:0] o_write_cnt,
  output logic [15:0] o_err_cnt
);

  localparam int MEM_SIZE = 1 << spi_mem_pkg::MEM_ADDR_W;

  typedef logic [spi_mem_pkg::MEM_ADDR_W-1:0] maddr_t;

  logic [7:0]  mem [MEM_SIZE];
  logic        sclk_q;
  logic [5:0]  bit_cnt;
  logic [31:0] sh;
  logic [31:0] sh_next;
  logic [7:0]  op;
  logic [7:0]  wdata;
  logic [7:0]  cur_byte;
  maddr_t      addr;
  // write-enable latch, cleared by every write
  logic        wel;
  // the command just before was a wren
  logic        last_wren;

  assign sh_next  = {sh[30:0], i_mosi};
  assign cur_byte = mem[addr];

  // start-up contents depend on every address bit
  initial
  begin
    int a;
    for (a = 0; a < MEM_SIZE; a++)
      mem[maddr_t'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'h5a;
  end

  always @(posedge i_clk_sys)
  begin
    if (!i_reset_n)
    begin
      sclk_q      <= 1'b0;
      bit_cnt     <= '0;
      sh          <= '0;
      op          <= '0;
      addr        <= '0;
      wdata       <= '0;
      wel         <= 1'b0;
      last_wren   <= 1'b0;
      o_miso      <= 1'b0;
      o_wren_cnt  <= '0;
      o_write_cnt <= '0;
      o_err_cnt   <= '0;
    end
    else
    begin
      sclk_q <= i_sclk;
      if (i_cs_n)
      begin
        o_miso  <= 1'b0;
        bit_cnt <= '0;
        // --------------------------------------------------
        // command completes when select goes high
        // --------------------------------------------------
        if (bit_cnt != '0)
        begin
          if (op == spi_mem_pkg::OP_WREN && bit_cnt == 6'd8)
          begin
            wel        <= 1'b1;
            last_wren  <= 1'b1;
            o_wren_cnt <= o_wren_cnt + 16'd1;
          end
          else if (op == spi_mem_pkg::OP_WRITE && bit_cnt == 6'd40)
          begin
            o_write_cnt <= o_write_cnt + 16'd1;
            // a write needs the latch and a wren right before it
            if (wel && last_wren)
              mem[addr] <= wdata;
            else
              o_err_cnt <= o_err_cnt + 16'd1;
            wel       <= 1'b0;
            last_wren <= 1'b0;
          end
          else if (op == spi_mem_pkg::OP_READ && bit_cnt == 6'd40)
            last_wren <= 1'b0;
          else
            o_err_cnt <= o_err_cnt + 16'd1;
        end
      end
      else
      begin
        // hold must stay released while selected
        if (!i_hold_n)
          o_err_cnt <= o_err_cnt + 16'd1;
        // mosi is taken on the rising sclk
        if (i_sclk && !sclk_q)
        begin
          sh      <= sh_next;
          bit_cnt <= bit_cnt + 6'd1;
          if (bit_cnt == 6'd7)
            op <= sh_next[7:0];
          if (bit_cnt == 6'd31)
            addr <= sh_next[spi_mem_pkg::MEM_ADDR_W-1:0];
          if (bit_cnt == 6'd39)
            wdata <= sh_next[7:0];
        end
        // read data leaves on the falling sclk, msb first
        if (!i_sclk && sclk_q && op == spi_mem_pkg::OP_READ &&
            bit_cnt >= 6'd32 && bit_cnt < 6'd40)
          o_miso <= cur_byte[~bit_cnt[2:0]];
      end
    end
  end

endmodule

`default_nettype wire

//--- test/mb128_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mb128_tb;

  localparam int HALF_CYCLES = 200;
  localparam int WAIT_LIMIT = 2000;
  localparam int NUM_TXN = 10;
  localparam int MEM_SIZE = 1 << spi_mem_pkg::MEM_ADDR_W;
  localparam int LOW_BITS = spi_mem_pkg::MEM_ADDR_W - mb128_proto_pkg::ADDR_BITS;

  typedef logic [spi_mem_pkg::MEM_ADDR_W-1:0] maddr_t;

  // one row of the transaction table
  typedef struct packed {
    logic                                       ident;
    logic                                       is_read;
    logic [mb128_proto_pkg::ADDR_BITS-1:0]      addr;
    logic [mb128_proto_pkg::LEN_BYTES_BITS-1:0] nbytes;
    logic [mb128_proto_pkg::LEN_BITS_BITS-1:0]  nbits;
  } txn_t;

  logic        clk_sys;
  logic        reset_n;
  logic        pad_clk;
  logic        pad_data;
  logic        active;
  logic        data_out;
  logic        ident_out;
  logic        sp_cs_n;
  logic        sp_clk;
  logic        sp_mosi;
  logic        sp_hold_n;
  logic        sp_miso;
  logic [15:0] wren_cnt;
  logic [15:0] write_cnt;
  logic [15:0] err_cnt;

  integer      seed;
  txn_t        txn_tab [NUM_TXN];
  logic [7:0]  ref_mem [MEM_SIZE];
  logic        got_data;
  logic        got_ident;
  int          exp_writes;

  mb128_top UUT (
    .i_clk_sys  (clk_sys),
    .i_reset_n  (reset_n),
    .i_pad_clk  (pad_clk),
    .i_pad_data (pad_data),
    .o_active   (active),
    .o_data     (data_out),
    .o_ident    (ident_out),
    .o_sp_cs_n  (sp_cs_n),
    .o_sp_clk   (sp_clk),
    .o_sp_mosi  (sp_mosi),
    .o_sp_hold_n(sp_hold_n),
    .i_sp_miso  (sp_miso)
  );

  spi_mem_model mem_model (
    .i_clk_sys  (clk_sys),
    .i_reset_n  (reset_n),
    .i_cs_n     (sp_cs_n),
    .i_sclk     (sp_clk),
    .i_mosi     (sp_mosi),
    .i_hold_n   (sp_hold_n),
    .o_miso     (sp_miso),
    .o_wren_cnt (wren_cnt),
    .o_write_cnt(write_cnt),
    .o_err_cnt  (err_cnt)
  );

  // 100 MHz system clock
  always #5 clk_sys = ~clk_sys;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // start-up memory contents, one value per address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'h5a;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "wait timed out");
  endtask

  // one host clock, data set up while the pad clock is low
  task automatic pad_bit(input logic d);
    @(posedge clk_sys);
    pad_data <= d;
    repeat (HALF_CYCLES) @(posedge clk_sys);
    pad_clk <= 1'b1;
    repeat (HALF_CYCLES) @(posedge clk_sys);
    // responses settle a few cycles after the rise
    @(negedge clk_sys);
    got_data  = data_out;
    got_ident = ident_out;
    @(posedge clk_sys);
    pad_clk <= 1'b0;
  endtask

  // lsb first
  task automatic pad_field(input logic [31:0] value, input int width);
    int i;
    for (i = 0; i < width; i++)
      pad_bit(value[5'(i)]);
  endtask

  task automatic wait_active(input logic level);
    int n;
    n = 0;
    while (active !== level && n < WAIT_LIMIT)
    begin
      @(negedge clk_sys);
      n++;
    end
    if (active !== level)
      give_up($sformatf("o_active did not go to %0b", level));
  endtask

  // all queued writes reach the memory and select is released
  task automatic wait_writes(input int count);
    int n;
    n = 0;
    while ((write_cnt != 16'(count) || sp_cs_n !== 1'b1) && n < WAIT_LIMIT)
    begin
      @(negedge clk_sys);
      n++;
    end
    if (write_cnt != 16'(count) || sp_cs_n !== 1'b1)
      give_up("serial memory writes did not complete");
  endtask

  // --------------------------------------------------
  // one full host transaction
  // --------------------------------------------------
  task automatic run_txn(input txn_t t);
    maddr_t     base;
    maddr_t     a;
    logic [7:0] wbyte;
    int         nbytes_i;
    int         nbits_i;
    int         k;
    int         b;
    base     = {t.addr, {LOW_BITS{1'b0}}};
    nbytes_i = int'(t.nbytes);
    nbits_i  = int'(t.nbits);
    // train-up, then ack slot and ident echo
    pad_field(32'(mb128_proto_pkg::SYNC_BYTE), 8);
    wait_active(1'b1);
    pad_bit(1'b0);
    pad_bit(t.ident);
    check_val(32'(got_ident), 32'(t.ident), "ident echo");
    pad_bit(t.is_read);
    pad_field(32'(t.addr), mb128_proto_pkg::ADDR_BITS);
    pad_field(32'(t.nbits), mb128_proto_pkg::LEN_BITS_BITS);
    pad_field(32'(t.nbytes), mb128_proto_pkg::LEN_BYTES_BITS);
    if (t.is_read)
    begin
      for (k = 0; k <= nbytes_i; k++)
      begin
        a = base + maddr_t'(k);
        // the byte after the full ones only gives its low bits
        for (b = 0; b < ((k == nbytes_i) ? nbits_i : 8); b++)
        begin
          pad_bit(1'b0);
          check_val(32'(got_data), 32'(ref_mem[a][3'(b)]),
                    $sformatf("read bit %0d of byte %0h", b, a));
        end
      end
      pad_field(32'd0, mb128_proto_pkg::TRAIL_READ);
    end
    else
    begin
      for (k = 0; k < nbytes_i; k++)
      begin
        wbyte = 8'($random(seed));
        pad_field(32'(wbyte), 8);
        ref_mem[base + maddr_t'(k)] = wbyte;
      end
      exp_writes += nbytes_i;
      // partial byte keeps its upper bits
      if (nbits_i != 0)
      begin
        wbyte = 8'($random(seed));
        pad_field(32'(wbyte), nbits_i);
        a = base + maddr_t'(nbytes_i);
        for (b = 0; b < nbits_i; b++)
          ref_mem[a][3'(b)] = wbyte[3'(b)];
        exp_writes++;
      end
      pad_field(32'd0, mb128_proto_pkg::TRAIL_WRITE);
    end
    wait_active(1'b0);
    wait_writes(exp_writes);
    check_val(32'(err_cnt), 32'd0, "serial memory protocol errors");
    check_val(32'(wren_cnt), 32'(write_cnt), "wren count against write count");
  endtask

  task automatic load_table();
    // ident, read, wire address, bytes, bits
    txn_tab[0] = '{1'b0, 1'b0, 10'd5, 17'd4, 3'd0};
    txn_tab[1] = '{1'b1, 1'b1, 10'd5, 17'd4, 3'd0};
    txn_tab[2] = '{1'b0, 1'b0, 10'd12, 17'd2, 3'd3};
    txn_tab[3] = '{1'b1, 1'b1, 10'd12, 17'd3, 3'd0};
    txn_tab[4] = '{1'b1, 1'b1, 10'd12, 17'd0, 3'd5};
    txn_tab[5] = '{1'b0, 1'b0, 10'd900, 17'd0, 3'd6};
    txn_tab[6] = '{1'b1, 1'b1, 10'd900, 17'd1, 3'd0};
    txn_tab[7] = '{1'b0, 1'b1, 10'd300, 17'd1, 3'd2};
    txn_tab[8] = '{1'b1, 1'b0, 10'd300, 17'd1, 3'd7};
    txn_tab[9] = '{1'b0, 1'b1, 10'd300, 17'd2, 3'd0};
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    int i;
    clk_sys    = 1'b0;
    reset_n    = 1'b0;
    pad_clk    = 1'b0;
    pad_data   = 1'b0;
    seed       = 32'hf223e7ca;
    exp_writes = 0;
    for (i = 0; i < MEM_SIZE; i++)
      ref_mem[maddr_t'(i)] = fill_byte(i);
    load_table();
    repeat (2) @(posedge clk_sys);
    reset_n <= 1'b1;
    @(negedge clk_sys);
    check_val(32'(active), 32'd0, "o_active after reset");
    check_val(32'(data_out), 32'd0, "o_data after reset");
    check_val(32'(ident_out), 32'd0, "o_ident after reset");
    check_val(32'(sp_cs_n), 32'd1, "spi select after reset");
    check_val(32'(sp_hold_n), 32'd0, "spi hold after reset");
    check_val(32'(sp_clk), 32'd0, "spi clock after reset");
    for (i = 0; i < NUM_TXN; i++)
      run_txn(txn_tab[i]);
    check_val(32'(write_cnt), 32'(exp_writes), "total serial memory writes");
    if (err_cnt == 16'd0 && wren_cnt == write_cnt)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      $display("serial memory saw %0d protocol errors", err_cnt);
      $display("Simulation FAILED");
      $fatal(1, "serial memory errors");
    end
  end

endmodule

`default_nettype wire

//--- list.f
verilog/mb128_proto_pkg.sv
verilog/spi_mem_pkg.sv
verilog/joypad_sampler.sv
verilog/mb128_protocol.sv
verilog/spi_mem_master.sv
verilog/mb128_top.sv
test/spi_mem_model.sv
test/mb128_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the mb128 testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module mb128_tb -Mdir "$OBJ" -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vmb128_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
fi

grep -q "Simulation PASSED" "$LOG"
if [ $? -ne 0 ]; then
  echo "pass message not found in $LOG"
  exit 1
fi

exit 0
